// File: verilog/axi_rd_xbar_defines.svh
`ifndef AXI_RD_XBAR_DEFINES_SVH
`define AXI_RD_XBAR_DEFINES_SVH

// Port counts
`define NB_INITIATOR 2
`define NB_TARGET    4

// Bus widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// ID width seen by the initiators
// The target side carries one extra initiator index on top
`define ID_WIDTH 4

// Memory map, one equal region per target
`define MAP_BASE    0
`define REGION_SIZE 4096

`endif

// File: verilog/axi_rd_xbar_pkg.sv
`include "axi_rd_xbar_defines.svh"

package axi_rd_xbar_pkg;

  // Index of an initiator port
  typedef logic [$clog2(`NB_INITIATOR)-1:0] init_idx_t;

  typedef logic [`ID_WIDTH-1:0]   id_t;
  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // Read response code
  typedef logic [1:0] resp_t;
  localparam resp_t OKAY = 2'b00;

  // Target side ID, initiator index on top of the original ID
  typedef struct packed {
    init_idx_t ini;
    id_t       id;
  } tid_t;

  // AR payload as presented to a target
  typedef struct packed {
    tid_t  id;
    addr_t addr;
  } ar_req_t;

  // R payload after the prefix is stripped
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
  } r_beat_t;

endpackage

// File: verilog/addr_map_pkg.sv
`include "axi_rd_xbar_defines.svh"

package addr_map_pkg;

  import axi_rd_xbar_pkg::*;

  typedef logic [$clog2(`NB_TARGET)-1:0] tgt_idx_t;

  localparam addr_t MAP_BASE_ADDR = `MAP_BASE;
  // One bit wider than an address so the top of the map fits
  localparam logic [`ADDR_WIDTH:0] MAP_SPAN = `NB_TARGET * `REGION_SIZE;

  // Region number of an address
  function automatic tgt_idx_t addr_to_target(addr_t addr);
    addr_t offset;
    offset = addr - MAP_BASE_ADDR;
    return tgt_idx_t'(offset / `REGION_SIZE);
  endfunction

  // Addresses below the base wrap into the extra bit and fail the compare
  function automatic logic addr_in_map(addr_t addr);
    logic [`ADDR_WIDTH:0] offset;
    offset = {1'b0, addr} - {1'b0, MAP_BASE_ADDR};
    return offset < MAP_SPAN;
  endfunction

endpackage

// File: verilog/ar_decoder.sv
`timescale 1ns/100ps

`include "axi_rd_xbar_defines.svh"

module ar_decoder
  import axi_rd_xbar_pkg::*;
  import addr_map_pkg::*;
(
  input  logic    [`NB_INITIATOR-1:0]                   ini_arvalid_i,
  input  id_t     [`NB_INITIATOR-1:0]                   ini_arid_i,
  input  addr_t   [`NB_INITIATOR-1:0]                   ini_araddr_i,
  input  logic    [`NB_TARGET-1:0][`NB_INITIATOR-1:0]   tgt_grant_i,
  output logic    [`NB_INITIATOR-1:0]                   ini_arready_o,
  output logic    [`NB_TARGET-1:0][`NB_INITIATOR-1:0]   tgt_req_o,
  output ar_req_t [`NB_INITIATOR-1:0]                   tgt_payload_o
);

  tgt_idx_t tgt_sel [`NB_INITIATOR];

  // Region decode per initiator
  always_comb begin
    for (int i = 0; i < `NB_INITIATOR; i++) begin
      tgt_sel[i] = addr_to_target(ini_araddr_i[i]);
    end
  end

  // Raise the one request line of the selected target
  always_comb begin
    tgt_req_o     = '0;
    ini_arready_o = '0;
    for (int i = 0; i < `NB_INITIATOR; i++) begin
      tgt_req_o[tgt_sel[i]][i] = ini_arvalid_i[i];
      ini_arready_o[i]         = tgt_grant_i[tgt_sel[i]][i];
    end
  end

  // Widen the ID with the initiator index
  always_comb begin
    for (int i = 0; i < `NB_INITIATOR; i++) begin
      tgt_payload_o[i].id.ini = init_idx_t'(i);
      tgt_payload_o[i].id.id  = ini_arid_i[i];
      tgt_payload_o[i].addr   = ini_araddr_i[i];
    end
  end

  // Out of range reads have no target and would alias onto one
  always_comb begin
    for (int i = 0; i < `NB_INITIATOR; i++) begin
      if (ini_arvalid_i[i]) begin
        addr_in_map_a: assert (addr_in_map(ini_araddr_i[i]))
          else $error("initiator %0d reads outside the map: %h", i, ini_araddr_i[i]);
      end
    end
  end

endmodule

// File: verilog/rr_arbiter.sv
`timescale 1ns/100ps

module rr_arbiter
  import axi_rd_xbar_pkg::*;
#(
  parameter type payload_t = ar_req_t,
  parameter int  NB_REQ    = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic     [NB_REQ-1:0] req_valid_i,
  input  payload_t [NB_REQ-1:0] req_payload_i,
  input  logic                  out_ready_i,
  output logic     [NB_REQ-1:0] req_ready_o,
  output logic                  out_valid_o,
  output payload_t              out_payload_o,
  output logic [((NB_REQ > 1) ? $clog2(NB_REQ) : 1)-1:0] out_src_o
);

  localparam int SRC_W = (NB_REQ > 1) ? $clog2(NB_REQ) : 1;

  typedef logic [SRC_W-1:0] src_t;

  logic     valid_q;
  src_t     last_q;
  payload_t payload_q;
  logic     load;
  logic     grant_found;
  src_t     grant_idx;

  // Output register is free or drains on this edge
  assign load = !valid_q || out_ready_i;

  // Search starts one past the last grant and wraps
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int i = 1; i <= NB_REQ; i++) begin
      idx = (int'(last_q) + i) % NB_REQ;
      if (!grant_found && req_valid_i[idx]) begin
        grant_found = 1'b1;
        grant_idx   = src_t'(idx);
      end
    end
  end

  always_comb begin
    req_ready_o = '0;
    if (load && grant_found) begin
      req_ready_o[grant_idx] = 1'b1;
    end
  end

  // Pointer resets to the last requester so requester 0 wins first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      last_q  <= src_t'(NB_REQ - 1);
    end else if (load) begin
      valid_q <= grant_found;
      if (grant_found) begin
        last_q <= grant_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load && grant_found) begin
      payload_q <= req_payload_i[grant_idx];
    end
  end

  assign out_valid_o   = valid_q;
  assign out_payload_o = payload_q;
  // The pointer holds the source of the item in the register
  assign out_src_o     = last_q;

  grant_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(req_ready_o) && ((req_ready_o & ~req_valid_i) == '0));

  out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_payload_o));

endmodule

// File: verilog/r_router.sv
`timescale 1ns/100ps

`include "axi_rd_xbar_defines.svh"

module r_router
  import axi_rd_xbar_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic  [`NB_TARGET-1:0]           tgt_rvalid_i,
  input  tid_t  [`NB_TARGET-1:0]           tgt_rid_i,
  input  data_t [`NB_TARGET-1:0]           tgt_rdata_i,
  input  resp_t [`NB_TARGET-1:0]           tgt_rresp_i,
  input  logic  [`NB_INITIATOR-1:0]        ini_rready_i,
  output logic  [`NB_TARGET-1:0]           tgt_rready_o,
  output logic  [`NB_INITIATOR-1:0]        ini_rvalid_o,
  output id_t   [`NB_INITIATOR-1:0]        ini_rid_o,
  output data_t [`NB_INITIATOR-1:0]        ini_rdata_o,
  output resp_t [`NB_INITIATOR-1:0]        ini_rresp_o
);

  logic    [`NB_INITIATOR-1:0][`NB_TARGET-1:0] ini_req;
  logic    [`NB_INITIATOR-1:0][`NB_TARGET-1:0] ini_grant;
  r_beat_t [`NB_TARGET-1:0]                    beat;
  r_beat_t [`NB_INITIATOR-1:0]                 ini_beat;

  // Strip the prefix and steer each beat by it
  for (genvar t = 0; t < `NB_TARGET; t++) begin : g_tgt
    assign beat[t] = '{id: tgt_rid_i[t].id, data: tgt_rdata_i[t], resp: tgt_rresp_i[t]};
    for (genvar i = 0; i < `NB_INITIATOR; i++) begin : g_dst
      assign ini_req[i][t] = tgt_rvalid_i[t] && (tgt_rid_i[t].ini == init_idx_t'(i));
    end
  end

  // A target is ready when the arbiter of its destination takes it
  always_comb begin
    tgt_rready_o = '0;
    for (int i = 0; i < `NB_INITIATOR; i++) begin
      tgt_rready_o = tgt_rready_o | ini_grant[i];
    end
  end

  for (genvar i = 0; i < `NB_INITIATOR; i++) begin : g_ini
    rr_arbiter #(
      .payload_t (r_beat_t),
      .NB_REQ    (`NB_TARGET)
    ) ini_arb_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid_i   (ini_req[i]),
      .req_payload_i (beat),
      .out_ready_i   (ini_rready_i[i]),
      .req_ready_o   (ini_grant[i]),
      .out_valid_o   (ini_rvalid_o[i]),
      .out_payload_o (ini_beat[i]),
      .out_src_o     ()
    );

    assign ini_rid_o[i]   = ini_beat[i].id;
    assign ini_rdata_o[i] = ini_beat[i].data;
    assign ini_rresp_o[i] = ini_beat[i].resp;
  end

endmodule

// File: verilog/axi_rd_xbar.sv
`timescale 1ns/100ps

`include "axi_rd_xbar_defines.svh"

module axi_rd_xbar
  import axi_rd_xbar_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // Initiator AR
  input  logic  [`NB_INITIATOR-1:0]  ini_arvalid_i,
  input  id_t   [`NB_INITIATOR-1:0]  ini_arid_i,
  input  addr_t [`NB_INITIATOR-1:0]  ini_araddr_i,
  output logic  [`NB_INITIATOR-1:0]  ini_arready_o,
  // Initiator R
  output logic  [`NB_INITIATOR-1:0]  ini_rvalid_o,
  output id_t   [`NB_INITIATOR-1:0]  ini_rid_o,
  output data_t [`NB_INITIATOR-1:0]  ini_rdata_o,
  output resp_t [`NB_INITIATOR-1:0]  ini_rresp_o,
  input  logic  [`NB_INITIATOR-1:0]  ini_rready_i,
  // Target AR
  output logic  [`NB_TARGET-1:0]     tgt_arvalid_o,
  output tid_t  [`NB_TARGET-1:0]     tgt_arid_o,
  output addr_t [`NB_TARGET-1:0]     tgt_araddr_o,
  input  logic  [`NB_TARGET-1:0]     tgt_arready_i,
  // Target R
  input  logic  [`NB_TARGET-1:0]     tgt_rvalid_i,
  input  tid_t  [`NB_TARGET-1:0]     tgt_rid_i,
  input  data_t [`NB_TARGET-1:0]     tgt_rdata_i,
  input  resp_t [`NB_TARGET-1:0]     tgt_rresp_i,
  output logic  [`NB_TARGET-1:0]     tgt_rready_o
);

  logic    [`NB_TARGET-1:0][`NB_INITIATOR-1:0] tgt_req;
  logic    [`NB_TARGET-1:0][`NB_INITIATOR-1:0] tgt_grant;
  ar_req_t [`NB_INITIATOR-1:0]                 tgt_payload;
  ar_req_t [`NB_TARGET-1:0]                    tgt_ar;

  ar_decoder ar_decoder_i (
    .ini_arvalid_i (ini_arvalid_i),
    .ini_arid_i    (ini_arid_i),
    .ini_araddr_i  (ini_araddr_i),
    .tgt_grant_i   (tgt_grant),
    .ini_arready_o (ini_arready_o),
    .tgt_req_o     (tgt_req),
    .tgt_payload_o (tgt_payload)
  );

  // One arbiter per target port, all initiators compete
  for (genvar t = 0; t < `NB_TARGET; t++) begin : g_tgt_arb
    rr_arbiter #(
      .payload_t (ar_req_t),
      .NB_REQ    (`NB_INITIATOR)
    ) tgt_arb_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_valid_i   (tgt_req[t]),
      .req_payload_i (tgt_payload),
      .out_ready_i   (tgt_arready_i[t]),
      .req_ready_o   (tgt_grant[t]),
      .out_valid_o   (tgt_arvalid_o[t]),
      .out_payload_o (tgt_ar[t]),
      .out_src_o     ()
    );

    assign tgt_arid_o[t]   = tgt_ar[t].id;
    assign tgt_araddr_o[t] = tgt_ar[t].addr;
  end

  r_router r_router_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .tgt_rvalid_i (tgt_rvalid_i),
    .tgt_rid_i    (tgt_rid_i),
    .tgt_rdata_i  (tgt_rdata_i),
    .tgt_rresp_i  (tgt_rresp_i),
    .ini_rready_i (ini_rready_i),
    .tgt_rready_o (tgt_rready_o),
    .ini_rvalid_o (ini_rvalid_o),
    .ini_rid_o    (ini_rid_o),
    .ini_rdata_o  (ini_rdata_o),
    .ini_rresp_o  (ini_rresp_o)
  );

endmodule

// File: testbench/tb_axi_rd_xbar.sv
`timescale 1ns/100ps

`include "axi_rd_xbar_defines.svh"

module tb_axi_rd_xbar
  import axi_rd_xbar_pkg::*;
  import addr_map_pkg::*;
();

  logic clk;
  logic rst_n;
  logic  [`NB_INITIATOR-1:0] ini_arvalid_i, ini_arready_o, ini_rvalid_o, ini_rready_i;
  id_t   [`NB_INITIATOR-1:0] ini_arid_i, ini_rid_o;
  addr_t [`NB_INITIATOR-1:0] ini_araddr_i;
  data_t [`NB_INITIATOR-1:0] ini_rdata_o;
  resp_t [`NB_INITIATOR-1:0] ini_rresp_o;
  logic  [`NB_TARGET-1:0]    tgt_arvalid_o, tgt_arready_i, tgt_rvalid_i, tgt_rready_o;
  tid_t  [`NB_TARGET-1:0]    tgt_arid_o, tgt_rid_i;
  addr_t [`NB_TARGET-1:0]    tgt_araddr_o;
  data_t [`NB_TARGET-1:0]    tgt_rdata_i;
  resp_t [`NB_TARGET-1:0]    tgt_rresp_i;

  logic [31:0] pat [0:191];
  logic [31:0] lfsr;
  int cur_test, test_errs, tests_run, tests_failed;
  bit timed_out;

  // One group of reads that share a test number
  int    n_e;
  int    e_ini [8];
  int    e_tgt [8];
  int    e_stall [8];
  id_t   e_id [8];
  addr_t e_addr [8];
  bit    e_acc [8];
  bit    e_tacc [8];
  bit    e_done [8];

  // Target model state
  bit    held [`NB_TARGET];
  int    wait_cnt [`NB_TARGET];
  tid_t  hold_id [`NB_TARGET];
  addr_t hold_addr [`NB_TARGET];
  tid_t  rq_id [`NB_TARGET][4];
  data_t rq_data [`NB_TARGET][4];
  int    rq_n [`NB_TARGET];
  int    rq_h [`NB_TARGET];
  int    rr_last [`NB_TARGET];
  int    exp_ord [`NB_TARGET][2];
  int    ord_len [`NB_TARGET];
  int    ord_pos [`NB_TARGET];

  axi_rd_xbar axi_rd_xbar_i (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Target rule: own index in the top byte, low address bits below
  function automatic data_t target_data(int t, addr_t a);
    return {8'(t), a[23:0]};
  endfunction

  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h80200003;
    return b;
  endfunction

  task automatic report_value(string what, logic [63:0] exp, logic [63:0] act);
    $display("FAILED test %0d %s: expected %h, actual %h", cur_test, what, exp, act);
    test_errs++;
  endtask

  task automatic report_error(string what);
    $display("Error in test %0d: %s", cur_test, what);
    test_errs++;
  endtask

  task automatic run_group(int first);
    int nxt [`NB_INITIATOR];
    int cyc, done_cnt, acc_cnt, e, c;
    n_e = 0;
    while (pat[(first + n_e) * 6] == pat[first * 6]) begin
      e_ini[n_e]   = int'(pat[(first + n_e) * 6 + 1]);
      e_id[n_e]    = id_t'(pat[(first + n_e) * 6 + 2]);
      e_addr[n_e]  = pat[(first + n_e) * 6 + 3];
      e_stall[n_e] = int'(pat[(first + n_e) * 6 + 4]);
      e_tgt[n_e]   = int'(pat[(first + n_e) * 6 + 5]);
      e_acc[n_e]   = 0;
      e_tacc[n_e]  = 0;
      e_done[n_e]  = 0;
      n_e++;
    end
    // Expected grant order at each target from the round-robin rule
    for (int t = 0; t < `NB_TARGET; t++) begin
      ord_len[t] = 0;
      ord_pos[t] = 0;
      rq_n[t] = 0;
      rq_h[t] = 0;
      held[t] = 0;
      for (int k = 1; k <= `NB_INITIATOR; k++) begin
        c = (rr_last[t] + k) % `NB_INITIATOR;
        for (int j = 0; j < n_e; j++) begin
          if (e_ini[j] == c && e_tgt[j] == t && (ord_len[t] == 0 || exp_ord[t][0] != c)) begin
            exp_ord[t][ord_len[t]] = c;
            ord_len[t]++;
          end
        end
      end
      if (ord_len[t] > 0) rr_last[t] = exp_ord[t][ord_len[t] - 1];
    end
    done_cnt = 0;
    acc_cnt = 0;
    for (cyc = 0; cyc < 300 && done_cnt < n_e; cyc++) begin
      @(negedge clk);
      for (int i = 0; i < `NB_INITIATOR; i++) begin
        nxt[i] = -1;
        for (int j = n_e - 1; j >= 0; j--) begin
          if (e_ini[j] == i && !e_acc[j]) nxt[i] = j;
        end
        ini_arvalid_i[i] = (nxt[i] >= 0);
        ini_arid_i[i]    = (nxt[i] >= 0) ? e_id[nxt[i]] : '0;
        ini_araddr_i[i]  = (nxt[i] >= 0) ? e_addr[nxt[i]] : '0;
        ini_rready_i[i]  = lfsr_bit();
      end
      for (int t = 0; t < `NB_TARGET; t++) begin
        tgt_arready_i[t] = held[t] && wait_cnt[t] == 0;
        tgt_rvalid_i[t]  = (rq_h[t] < rq_n[t]) && acc_cnt == n_e;
        tgt_rid_i[t]     = rq_id[t][rq_h[t]];
        tgt_rdata_i[t]   = rq_data[t][rq_h[t]];
        tgt_rresp_i[t]   = OKAY;
      end
      #1;
      for (int i = 0; i < `NB_INITIATOR; i++) begin
        if (ini_arvalid_i[i] && ini_arready_o[i]) begin
          if (held[e_tgt[nxt[i]]] && !tgt_arready_i[e_tgt[nxt[i]]])
            report_error($sformatf("initiator %0d granted while its target stalls", i));
          e_acc[nxt[i]] = 1;
        end
      end
      for (int t = 0; t < `NB_TARGET; t++) begin
        if (tgt_arvalid_o[t]) begin
          if (!held[t]) begin
            e = -1;
            for (int j = 0; j < n_e; j++) begin
              if (e_acc[j] && !e_tacc[j] && tgt_arid_o[t] == {init_idx_t'(e_ini[j]), e_id[j]})
                e = j;
            end
            if (e < 0) begin
              report_error($sformatf("target %0d shows an unknown read id %h", t, tgt_arid_o[t]));
            end else begin
              if (e_tgt[e] != t) report_value("target", e_tgt[e], t);
              if (tgt_araddr_o[t] != e_addr[e]) report_value("araddr", e_addr[e], tgt_araddr_o[t]);
              held[t] = 1;
              hold_id[t] = tgt_arid_o[t];
              hold_addr[t] = tgt_araddr_o[t];
              wait_cnt[t] = e_stall[e];
              e_tacc[e] = 1;
            end
          end else if (tgt_arid_o[t] != hold_id[t] || tgt_araddr_o[t] != hold_addr[t]) begin
            report_value("held AR payload", {hold_id[t], hold_addr[t]},
                         {tgt_arid_o[t], tgt_araddr_o[t]});
          end else if (tgt_arready_i[t]) begin
            if (ord_pos[t] < ord_len[t] && exp_ord[t][ord_pos[t]] != hold_id[t].ini)
              report_value("grant order", exp_ord[t][ord_pos[t]], hold_id[t].ini);
            ord_pos[t]++;
            rq_id[t][rq_n[t]] = hold_id[t];
            rq_data[t][rq_n[t]] = target_data(t, hold_addr[t]);
            rq_n[t]++;
            acc_cnt++;
            held[t] = 0;
          end else if (wait_cnt[t] > 0) begin
            wait_cnt[t]--;
          end
        end else if (held[t]) begin
          report_error($sformatf("target %0d arvalid dropped before the handshake", t));
          held[t] = 0;
        end
        if (tgt_rvalid_i[t] && tgt_rready_o[t]) rq_h[t]++;
      end
      for (int i = 0; i < `NB_INITIATOR; i++) begin
        if (ini_rvalid_o[i] && ini_rready_i[i]) begin
          e = -1;
          for (int j = 0; j < n_e; j++) begin
            if (e_ini[j] == i && e_id[j] == ini_rid_o[i] && e_tacc[j] && !e_done[j]) e = j;
          end
          if (e < 0) begin
            report_error($sformatf("initiator %0d got a beat with unknown id %h", i, ini_rid_o[i]));
          end else begin
            if (ini_rdata_o[i] != target_data(e_tgt[e], e_addr[e]))
              report_value("rdata", target_data(e_tgt[e], e_addr[e]), ini_rdata_o[i]);
            if (ini_rresp_o[i] != OKAY) report_value("rresp", OKAY, ini_rresp_o[i]);
            e_done[e] = 1;
            done_cnt++;
          end
        end
      end
    end
    if (done_cnt < n_e) begin
      report_error("timed out waiting for read data");
      timed_out = 1'b1;
    end
  endtask

  task automatic finish_test();
    $display("test %0d finished with %0d errors", cur_test, test_errs);
    tests_run++;
    if (test_errs != 0) tests_failed++;
  endtask

  initial begin
    int p;
    $readmemh("testbench/xbar_patterns.txt", pat);
    lfsr = 32'hdfe8;
    rst_n = 1'b0;
    // Requests during reset must not reach the outputs
    ini_arvalid_i = '1;
    ini_arid_i = '0;
    ini_araddr_i = '0;
    ini_rready_i = '0;
    tgt_arready_i = '0;
    tgt_rvalid_i = '1;
    tgt_rid_i = '0;
    tgt_rdata_i = '0;
    tgt_rresp_i = '0;
    tests_run = 0;
    tests_failed = 0;
    timed_out = 1'b0;
    for (int t = 0; t < `NB_TARGET; t++) rr_last[t] = `NB_INITIATOR - 1;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    ini_arvalid_i = '0;
    tgt_rvalid_i = '0;
    // Reset state, nothing valid while idle
    cur_test = 0;
    test_errs = 0;
    for (int c = 0; c < 4; c++) begin
      @(negedge clk);
      #1;
      if (tgt_arvalid_o !== '0) report_value("tgt_arvalid_o", 0, tgt_arvalid_o);
      if (ini_rvalid_o !== '0) report_value("ini_rvalid_o", 0, ini_rvalid_o);
    end
    finish_test();
    p = 0;
    while (pat[p * 6] !== 32'hff && p < 32 && !timed_out) begin
      cur_test = int'(pat[p * 6]);
      test_errs = 0;
      run_group(p);
      finish_test();
      p = p + n_e;
    end
    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/xbar_patterns.txt
// test initiator id address stall expected_target
// Lines with the same test number are issued together
01 0 3 00000010 0 0
02 1 5 00001024 0 1
03 0 a 00003ffc 0 3
// Round-robin, both initiators at target 2 twice
04 0 1 00002000 0 2
04 1 2 00002004 0 2
05 0 6 00002100 0 2
05 1 7 00002108 0 2
// Back-pressure at target 1
06 0 b 00001300 5 1
06 1 9 00001200 0 1
// Concurrent reads, then two outstanding at one initiator
07 0 c 00000400 0 0
07 1 d 00003400 0 3
08 0 2 00001800 0 1
08 0 4 00002800 0 2
ff 0 0 00000000 0 0

// File: axi_rd_xbar.f
+incdir+verilog
verilog/axi_rd_xbar_pkg.sv
verilog/addr_map_pkg.sv
verilog/ar_decoder.sv
verilog/rr_arbiter.sv
verilog/r_router.sv
verilog/axi_rd_xbar.sv
testbench/tb_axi_rd_xbar.sv

// File: Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wall
TOP        ?= tb_axi_rd_xbar
FILELIST   ?= axi_rd_xbar.f
RTL_TOP    ?= axi_rd_xbar
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test OK" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall -Iverilog --top-module $(RTL_TOP) \
	  verilog/axi_rd_xbar_pkg.sv verilog/addr_map_pkg.sv verilog/ar_decoder.sv \
	  verilog/rr_arbiter.sv verilog/r_router.sv verilog/axi_rd_xbar.sv

clean:
	rm -rf obj_dir $(LOG)
